/* list.f */
logic/adma_pkg.sv
logic/system_ram.sv
logic/ram_arbiter.sv
logic/adma_descriptor_fetch.sv
logic/adma_data_mover.sv
logic/data_fifo.sv
logic/adma_top.sv
tb/tb_adma.sv

/* run.sh */
#!/bin/sh
# build and run the adma testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_adma -f list.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_adma)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
   exit 0
fi
exit 1

/* tb/tb_adma.sv */
/*
 * adma engine testbench
 * host loads ram and descriptors, card side pops tx and pushes rx,
 * scoreboard queue and assertions check the moved words
 */
`timescale 1ns/1ps
`default_nettype none

module tb_adma;

   localparam int ADDR_W     = 8;
   localparam int FIFO_DEPTH = 16;

   // words per test
   localparam int n_tx   = 8;
   localparam int n_rx   = 6;
   localparam int n_a    = 5;
   localparam int n_nop  = 3;
   localparam int n_b    = 4;
   localparam int n_inv  = 3;
   localparam int n_bp   = 40;   // longer than one buffer

   // load plus move for each test, with room for descriptor traffic
   // the back-pressure card pops about one cycle in eight
   localparam int test_cycles = 10 + 4 + (2 * n_tx + 32) + (2 * n_rx + 32) +
                                (2 * (n_a + n_nop + n_b) + 48) + (2 * n_inv + 32) +
                                (8 * n_bp + 32);
   localparam int timeout_cycles = 4 * test_cycles;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        host_wr;
   logic        host_rd;
   logic [7:0]  host_addr;
   logic [31:0] host_wdata;
   logic [31:0] host_rdata;
   logic        host_rvalid;
   logic        start;
   logic [7:0]  desc_base;
   logic        dir;
   logic        busy;
   logic        done;
   logic        error;
   logic        tx_rd = 1'b0;   // driven by the card model only
   logic [31:0] tx_dout;
   logic        tx_empty;
   logic        rx_wr;
   logic [31:0] rx_din;
   logic        rx_full;

   logic [15:0] lfsr = 16'd46600;
   logic [31:0] tx_exp[$];        // words the card should pop, in order
   logic [31:0] rx_words[$];
   logic [31:0] exp_word;
   logic        pace_random;
   logic        saw_tx_full;      // tx buffer reached full while paced
   logic        allow_done;
   logic        allow_error;
   int          cycle_count = 0;
   string       test_name = "reset";

   always #2 clk = ~clk;

   adma_top #(.ADDR_W(ADDR_W), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
      .CLK(clk), .rst_n(rst_n),
      .host_wr(host_wr), .host_rd(host_rd), .host_addr(host_addr),
      .host_wdata(host_wdata), .host_rdata(host_rdata), .host_rvalid(host_rvalid),
      .start(start), .desc_base(desc_base), .dir(dir),
      .busy(busy), .done(done), .error(error),
      .tx_rd(tx_rd), .tx_dout(tx_dout), .tx_empty(tx_empty),
      .rx_wr(rx_wr), .rx_din(rx_din), .rx_full(rx_full)
   );

   ////////////////////
   // helpers
   ////////////////////
   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic fail_value(input logic [31:0] expected, input logic [31:0] actual);
      stop_on_error($sformatf("FAILED %s: expected %h, actual %h", test_name, expected, actual));
   endtask

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [31:0] desc_attr(input logic valid, input logic last,
                                             input logic [1:0] act, input logic [15:0] len);
      return {valid, last, 2'b00, act, 10'd0, len};
   endfunction

   // all host tasks start and end on a falling edge
   task automatic host_write(input logic [7:0] a, input logic [31:0] d);
      host_wr    = 1'b1;
      host_addr  = a;
      host_wdata = d;
      @(negedge clk);
      host_wr = 1'b0;
   endtask

   task automatic host_read(input logic [7:0] a, output logic [31:0] d);
      host_rd   = 1'b1;
      host_addr = a;
      @(negedge clk);
      host_rd = 1'b0;
      assert (host_rvalid) else stop_on_error("host read got no host_rvalid one cycle later");
      d = host_rdata;
   endtask

   task automatic write_desc(input logic [7:0] at, input logic [31:0] w0,
                             input logic [7:0] target);
      host_write(at, w0);
      host_write(at + 8'd1, {24'd0, target});
   endtask

   // random words into ram, queued for the card when they should show up
   task automatic load_area(input logic [7:0] base, input int n, input logic expect_tx);
      logic [31:0] w;
      for (int i = 0; i < n; i++) begin
         w = rand_bits(32);
         host_write(base + 8'(i), w);
         if (expect_tx) tx_exp.push_back(w);
      end
   endtask

   task automatic run_chain(input logic [7:0] base, input logic d, output logic ended_err);
      start     = 1'b1;
      desc_base = base;
      dir       = d;
      @(negedge clk);
      start = 1'b0;
      while (!done && !error) @(negedge clk);
      ended_err = error;
   endtask

   task automatic drain_tx();
      while (tx_exp.size() != 0) @(negedge clk);
      repeat (4) @(negedge clk);   // catch any stray word
      assert (tx_empty) else stop_on_error("tx fifo still holds words after the chain");
   endtask

   ////////////////////
   // card side model
   ////////////////////
   always @(negedge clk) begin
      tx_rd = 1'b0;
      if (pace_random && i_dut.tx_full) saw_tx_full = 1'b1;
      if (rst_n && !tx_empty && (!pace_random || rand_bits(3) == 0)) begin
         assert (tx_exp.size() != 0) else stop_on_error("tx fifo gave a word nobody expected");
         exp_word = tx_exp.pop_front();
         assert (tx_dout == exp_word) else fail_value(exp_word, tx_dout);
         tx_rd = 1'b1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         stop_on_error("timeout: the tests did not finish within the cycle limit");
      end
   end

   ////////////////////
   // protocol checks
   ////////////////////
   a_rvalid_timing: assert property (@(posedge clk) disable iff (!rst_n)
      host_rvalid == $past(host_rd))
      else stop_on_error("host_rvalid did not follow host_rd by exactly one cycle");
   a_not_both: assert property (@(posedge clk) disable iff (!rst_n) !(done && error))
      else stop_on_error("done and error were high together");
   a_done_ok: assert property (@(posedge clk) disable iff (!rst_n) done |-> allow_done)
      else stop_on_error("done pulsed where the chain must end in error");
   a_error_ok: assert property (@(posedge clk) disable iff (!rst_n) error |-> allow_error)
      else stop_on_error("error pulsed on a valid chain");
   a_tx_room: assert property (@(posedge clk) disable iff (!rst_n)
      i_dut.tx_wr |-> !i_dut.tx_full)
      else stop_on_error("tx fifo written while full");
   a_rx_data: assert property (@(posedge clk) disable iff (!rst_n)
      i_dut.rx_rd |-> !i_dut.rx_empty)
      else stop_on_error("rx fifo read while empty");

   ////////////////////
   // tests
   ////////////////////
   initial begin
      logic [31:0] w;
      logic [31:0] r;
      logic        ended_err;
      rst_n       = 1'b0;
      host_wr     = 1'b0;
      host_rd     = 1'b0;
      host_addr   = '0;
      host_wdata  = '0;
      start       = 1'b0;
      desc_base   = '0;
      dir         = 1'b0;
      rx_wr       = 1'b0;
      rx_din      = '0;
      pace_random = 1'b0;
      saw_tx_full = 1'b0;
      allow_done  = 1'b1;
      allow_error = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;

      // reset state, then one host round trip
      assert ({busy, done, error, host_rvalid, tx_empty, rx_full} == 6'b000010)
         else fail_value(32'b000010, {26'd0, busy, done, error, host_rvalid, tx_empty, rx_full});
      w = rand_bits(32);
      host_write(8'hFF, w);
      host_read(8'hFF, r);
      assert (r == w) else fail_value(w, r);

      test_name = "single transmit";
      load_area(8'h40, n_tx, 1'b1);
      write_desc(8'h00, desc_attr(1'b1, 1'b1, adma_pkg::act_tran, 16'(n_tx)), 8'h40);
      run_chain(8'h00, 1'b0, ended_err);
      assert (!ended_err) else fail_value(32'd0, 32'd1);
      drain_tx();

      test_name = "receive to ram";
      write_desc(8'h10, desc_attr(1'b1, 1'b1, adma_pkg::act_tran, 16'(n_rx)), 8'h60);
      start     = 1'b1;
      desc_base = 8'h10;
      dir       = 1'b1;
      @(negedge clk);
      start = 1'b0;
      for (int i = 0; i < n_rx; i++) begin
         rx_words.push_back(rand_bits(32));
         while (rx_full) @(negedge clk);
         rx_wr  = 1'b1;
         rx_din = rx_words[i];
         @(negedge clk);
         rx_wr = 1'b0;
      end
      while (!done && !error) @(negedge clk);
      assert (done) else fail_value(32'd1, 32'd0);
      for (int i = 0; i < n_rx; i++) begin
         host_read(8'h60 + 8'(i), r);
         assert (r == rx_words[i]) else fail_value(rx_words[i], r);
      end
      assert (rx_empty_now()) else stop_on_error("rx fifo not empty after receive");

      test_name = "chain walking";
      load_area(8'h80, n_a, 1'b1);
      load_area(8'h90, n_nop, 1'b0);   // nop area, never delivered
      load_area(8'hA0, n_b, 1'b1);
      write_desc(8'h20, desc_attr(1'b1, 1'b0, adma_pkg::act_tran, 16'(n_a)), 8'h80);
      write_desc(8'h22, desc_attr(1'b1, 1'b0, adma_pkg::act_nop, 16'(n_nop)), 8'h90);
      write_desc(8'h24, desc_attr(1'b1, 1'b0, adma_pkg::act_link, 16'd0), 8'h30);
      write_desc(8'h30, desc_attr(1'b1, 1'b1, adma_pkg::act_tran, 16'(n_b)), 8'hA0);
      run_chain(8'h20, 1'b0, ended_err);
      assert (!ended_err) else fail_value(32'd0, 32'd1);
      drain_tx();

      test_name   = "invalid descriptor";
      allow_done  = 1'b0;
      allow_error = 1'b1;
      load_area(8'hB0, n_inv, 1'b1);
      write_desc(8'h38, desc_attr(1'b1, 1'b0, adma_pkg::act_tran, 16'(n_inv)), 8'hB0);
      write_desc(8'h3A, desc_attr(1'b0, 1'b0, adma_pkg::act_tran, 16'd4), 8'hB0);
      run_chain(8'h38, 1'b0, ended_err);
      assert (ended_err) else fail_value(32'd1, 32'd0);
      drain_tx();
      allow_done  = 1'b1;
      allow_error = 1'b0;

      test_name = "back-pressure";
      load_area(8'hC0, n_bp, 1'b1);
      write_desc(8'h3C, desc_attr(1'b1, 1'b1, adma_pkg::act_tran, 16'(n_bp)), 8'hC0);
      pace_random = 1'b1;   // card pops on lfsr chosen cycles
      run_chain(8'h3C, 1'b0, ended_err);
      assert (!ended_err) else fail_value(32'd0, 32'd1);
      drain_tx();
      pace_random = 1'b0;
      assert (saw_tx_full) else stop_on_error("tx fifo never filled during the back-pressure test");

      $display("TEST PASSED");
      $finish;
   end

   function automatic logic rx_empty_now();
      return i_dut.rx_empty;
   endfunction

endmodule

`default_nettype wire

/* logic/adma_top.sv */
/*
 * adma engine top
 * descriptor fetcher, data mover, tx/rx buffers and the shared system ram
 */
`timescale 1ns/1ps
`default_nettype none

module adma_top #(
   parameter int ADDR_W     = 8,
   parameter int FIFO_DEPTH = 16
) (
   input  wire                         CLK,
   input  wire                         rst_n,
   input  wire                         host_wr,
   input  wire                         host_rd,
   input  wire [ADDR_W-1:0]            host_addr,
   input  wire [adma_pkg::data_w-1:0]  host_wdata,
   output logic [adma_pkg::data_w-1:0] host_rdata,
   output logic                        host_rvalid,
   input  wire                         start,
   input  wire [ADDR_W-1:0]            desc_base,
   input  wire                         dir,
   output logic                        busy,
   output logic                        done,
   output logic                        error,
   input  wire                         tx_rd,
   output logic [adma_pkg::data_w-1:0] tx_dout,
   output logic                        tx_empty,
   input  wire                         rx_wr,
   input  wire [adma_pkg::data_w-1:0]  rx_din,
   output logic                        rx_full
);

   logic                        dir_q;   // direction of the running chain
   logic                        host_req;
   logic [ADDR_W-1:0]           ram_addr;
   logic                        ram_we;
   logic [adma_pkg::data_w-1:0] ram_wdata;
   logic [adma_pkg::data_w-1:0] ram_rdata;
   logic                        fetch_req, fetch_gnt, fetch_rvalid;
   logic [ADDR_W-1:0]           fetch_addr;
   logic                        mover_req, mover_we, mover_gnt, mover_rvalid;
   logic [ADDR_W-1:0]           mover_addr;
   logic [adma_pkg::data_w-1:0] mover_wdata;
   logic                        job_go, job_done;
   logic [ADDR_W-1:0]           job_addr;
   logic [adma_pkg::len_w-1:0]  job_len;
   logic                        tx_wr, tx_full;
   logic [adma_pkg::data_w-1:0] tx_din;
   logic                        rx_rd, rx_empty;
   logic [adma_pkg::data_w-1:0] rx_dout;

   assign host_req   = host_wr || host_rd;
   assign host_rdata = ram_rdata;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         dir_q <= 1'b0;
      end else if (start && !busy) begin
         dir_q <= dir;
      end
   end

   ////////////////////
   // shared ram
   ////////////////////
   system_ram #(.ADDR_W(ADDR_W)) i_ram (
      .CLK(CLK), .addr(ram_addr), .we(ram_we), .wdata(ram_wdata), .rdata(ram_rdata)
   );

   ram_arbiter #(.ADDR_W(ADDR_W)) i_arb (
      .CLK(CLK), .rst_n(rst_n),
      .host_req(host_req), .host_we(host_wr), .host_addr(host_addr),
      .host_wdata(host_wdata), .host_rvalid(host_rvalid),
      .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_gnt(fetch_gnt),
      .fetch_rvalid(fetch_rvalid),
      .mover_req(mover_req), .mover_we(mover_we), .mover_addr(mover_addr),
      .mover_wdata(mover_wdata), .mover_gnt(mover_gnt), .mover_rvalid(mover_rvalid),
      .ram_addr(ram_addr), .ram_we(ram_we), .ram_wdata(ram_wdata)
   );

   ////////////////////
   // dma engine
   ////////////////////
   adma_descriptor_fetch #(.ADDR_W(ADDR_W)) i_fetch (
      .CLK(CLK), .rst_n(rst_n), .start(start), .desc_base(desc_base),
      .busy(busy), .done(done), .error(error),
      .req(fetch_req), .addr(fetch_addr), .gnt(fetch_gnt),
      .rvalid(fetch_rvalid), .rdata(ram_rdata),
      .job_go(job_go), .job_addr(job_addr), .job_len(job_len), .job_done(job_done)
   );

   adma_data_mover #(.ADDR_W(ADDR_W)) i_mover (
      .CLK(CLK), .rst_n(rst_n), .dir(dir_q),
      .job_go(job_go), .job_addr(job_addr), .job_len(job_len), .job_done(job_done),
      .req(mover_req), .we(mover_we), .addr(mover_addr), .wdata(mover_wdata),
      .gnt(mover_gnt), .rvalid(mover_rvalid), .rdata(ram_rdata),
      .tx_full(tx_full), .tx_wr(tx_wr), .tx_din(tx_din),
      .rx_empty(rx_empty), .rx_rd(rx_rd), .rx_dout(rx_dout)
   );

   // card side buffers
   data_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_tx_fifo (
      .CLK(CLK), .rst_n(rst_n), .wr(tx_wr), .din(tx_din),
      .rd(tx_rd), .dout(tx_dout), .full(tx_full), .empty(tx_empty)
   );

   data_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_rx_fifo (
      .CLK(CLK), .rst_n(rst_n), .wr(rx_wr), .din(rx_din),
      .rd(rx_rd), .dout(rx_dout), .full(rx_full), .empty(rx_empty)
   );

endmodule

`default_nettype wire

/* logic/data_fifo.sv */
/*
 * data fifo
 * synchronous word buffer with full and empty flags, head word on dout
 */
`timescale 1ns/1ps
`default_nettype none

module data_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  wire                         CLK,
   input  wire                         rst_n,
   input  wire                         wr,
   input  wire [adma_pkg::data_w-1:0]  din,
   input  wire                         rd,
   output logic [adma_pkg::data_w-1:0] dout,
   output logic                        full,
   output logic                        empty
);

   localparam int ptr_w = $clog2(FIFO_DEPTH);
   localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

   logic [adma_pkg::data_w-1:0] mem [FIFO_DEPTH];
   logic [ptr_w-1:0]            wr_ptr;
   logic [ptr_w-1:0]            rd_ptr;
   logic [cnt_w-1:0]            count;

   assign dout  = mem[rd_ptr];
   assign full  = (count == cnt_w'(FIFO_DEPTH));
   assign empty = (count == '0);

   always_ff @(posedge CLK) begin
      if (wr) mem[wr_ptr] <= din;
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr) begin
            wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd) begin
            rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or push+pop
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge CLK) disable iff (!rst_n) wr |-> !full);
   a_no_underflow: assert property (@(posedge CLK) disable iff (!rst_n) rd |-> !empty);

endmodule

`default_nettype wire

/* logic/adma_data_mover.sv */
/*
 * adma data mover
 * copies one tran job between ram and the tx or rx buffer,
 * stalling its ram requests while the buffer cannot take or give a word
 */
`timescale 1ns/1ps
`default_nettype none

module adma_data_mover #(
   parameter int ADDR_W = 8
) (
   input  wire                         CLK,
   input  wire                         rst_n,
   input  wire                         dir,       // 0 ram->tx, 1 rx->ram
   input  wire                         job_go,
   input  wire [ADDR_W-1:0]            job_addr,
   input  wire [adma_pkg::len_w-1:0]   job_len,
   output logic                        job_done,
   output logic                        req,
   output logic                        we,
   output logic [ADDR_W-1:0]           addr,
   output logic [adma_pkg::data_w-1:0] wdata,
   input  wire                         gnt,
   input  wire                         rvalid,
   input  wire [adma_pkg::data_w-1:0]  rdata,
   input  wire                         tx_full,
   output logic                        tx_wr,
   output logic [adma_pkg::data_w-1:0] tx_din,
   input  wire                         rx_empty,
   output logic                        rx_rd,
   input  wire [adma_pkg::data_w-1:0]  rx_dout
);

   logic                        active;
   logic                        inflight;    // ram read granted, data not back yet
   logic                        hold_valid;
   logic [adma_pkg::data_w-1:0] hold_data;   // word waiting for a tx slot
   logic [adma_pkg::len_w-1:0]  remain;      // words not yet requested
   logic [ADDR_W-1:0]           ptr;
   logic                        tx_req;
   logic                        rx_req;
   logic                        finished;

   ////////////////////
   // request side
   ////////////////////
   // hold must be free or draining by the time the read returns
   assign tx_req = active && !dir && (remain != '0) && !inflight &&
                   !(hold_valid && tx_full);
   assign rx_req = active && dir && (remain != '0) && !rx_empty;

   assign req   = tx_req || rx_req;
   assign we    = dir;
   assign addr  = ptr;
   assign wdata = rx_dout;        // head word, popped on grant
   assign rx_rd = rx_req && gnt;

   assign tx_wr  = hold_valid && !tx_full;
   assign tx_din = hold_data;

   assign finished = active && (remain == '0) && !inflight && !hold_valid;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         active     <= 1'b0;
         inflight   <= 1'b0;
         hold_valid <= 1'b0;
         job_done   <= 1'b0;
      end else begin
         job_done <= 1'b0;
         if (job_go) begin
            active <= 1'b1;
            ptr    <= job_addr;
            remain <= job_len;
         end else if (finished) begin
            active   <= 1'b0;
            job_done <= 1'b1;
         end
         if (req && gnt) begin
            ptr    <= ptr + ADDR_W'(1);
            remain <= remain - 1'b1;
         end
         if (tx_req && gnt) begin
            inflight <= 1'b1;
         end else if (rvalid) begin
            inflight <= 1'b0;
         end
         if (rvalid) begin
            hold_data  <= rdata;
            hold_valid <= 1'b1;
         end else if (tx_wr) begin
            hold_valid <= 1'b0;
         end
      end
   end

   // read data never lands on an unsent word
   a_hold_free: assert property (@(posedge CLK) disable iff (!rst_n)
      rvalid |-> !hold_valid);

endmodule

`default_nettype wire

/* logic/adma_descriptor_fetch.sv */
/*
 * adma descriptor fetcher
 * walks the descriptor chain in ram and hands tran jobs to the data mover
 */
`timescale 1ns/1ps
`default_nettype none

module adma_descriptor_fetch #(
   parameter int ADDR_W = 8
) (
   input  wire                         CLK,
   input  wire                         rst_n,
   input  wire                         start,
   input  wire [ADDR_W-1:0]            desc_base,
   output logic                        busy,
   output logic                        done,
   output logic                        error,
   output logic                        req,
   output logic [ADDR_W-1:0]           addr,
   input  wire                         gnt,
   input  wire                         rvalid,
   input  wire [adma_pkg::data_w-1:0]  rdata,
   output logic                        job_go,
   output logic [ADDR_W-1:0]           job_addr,
   output logic [adma_pkg::len_w-1:0]  job_len,
   input  wire                         job_done
);

   typedef enum logic [2:0] {
      s_idle, s_attr_req, s_attr_wait, s_addr_req, s_addr_wait, s_job
   } state_t;

   state_t               state;
   logic [ADDR_W-1:0]    desc_ptr;   // word 0 of current descriptor
   adma_pkg::adma_attr_u attr_in;
   adma_pkg::adma_attr_u attr_q;
   logic                 job_open;

   assign attr_in.raw = rdata;
   assign busy = (state != s_idle);
   assign req  = (state == s_attr_req) || (state == s_addr_req);
   assign addr = (state == s_addr_req) ? desc_ptr + ADDR_W'(1) : desc_ptr;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         state  <= s_idle;
         done   <= 1'b0;
         error  <= 1'b0;
         job_go <= 1'b0;
      end else begin
         done   <= 1'b0;
         error  <= 1'b0;
         job_go <= 1'b0;
         case (state)
            s_idle: if (start) begin
               desc_ptr <= desc_base;
               state    <= s_attr_req;
            end
            s_attr_req: if (gnt) state <= s_attr_wait;
            s_attr_wait: if (rvalid) begin
               attr_q <= attr_in;
               if (!attr_in.attr.valid) begin
                  error <= 1'b1;   // chain aborted
                  state <= s_idle;
               end else begin
                  state <= s_addr_req;
               end
            end
            s_addr_req: if (gnt) state <= s_addr_wait;
            s_addr_wait: if (rvalid) begin
               case (attr_q.attr.act)
                  adma_pkg::act_tran: begin
                     job_go   <= 1'b1;
                     job_addr <= rdata[ADDR_W-1:0];
                     job_len  <= attr_q.attr.length;
                     state    <= s_job;
                  end
                  adma_pkg::act_link: begin
                     desc_ptr <= rdata[ADDR_W-1:0];
                     done     <= attr_q.attr.end_flag;
                     state    <= attr_q.attr.end_flag ? s_idle : s_attr_req;
                  end
                  default: begin   // nop and reserved
                     desc_ptr <= desc_ptr + ADDR_W'(2);
                     done     <= attr_q.attr.end_flag;
                     state    <= attr_q.attr.end_flag ? s_idle : s_attr_req;
                  end
               endcase
            end
            s_job: if (job_done) begin
               desc_ptr <= desc_ptr + ADDR_W'(2);
               done     <= attr_q.attr.end_flag;
               state    <= attr_q.attr.end_flag ? s_idle : s_attr_req;
            end
            default: state <= s_idle;
         endcase
      end
   end

   // open from job_go until the mover reports back
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         job_open <= 1'b0;
      end else if (job_go) begin
         job_open <= 1'b1;
      end else if (job_done) begin
         job_open <= 1'b0;
      end
   end

   a_one_job: assert property (@(posedge CLK) disable iff (!rst_n)
      job_go |-> !job_open);
   a_done_owned: assert property (@(posedge CLK) disable iff (!rst_n)
      job_done |-> job_open);

endmodule

`default_nettype wire

/* logic/ram_arbiter.sv */
/*
 * ram arbiter
 * fixed priority host > fetcher > mover on the single ram port,
 * read valid strobes steered back to whoever issued the read
 */
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter #(
   parameter int ADDR_W = 8
) (
   input  wire                         CLK,
   input  wire                         rst_n,
   input  wire                         host_req,
   input  wire                         host_we,
   input  wire [ADDR_W-1:0]            host_addr,
   input  wire [adma_pkg::data_w-1:0]  host_wdata,
   output logic                        host_rvalid,
   input  wire                         fetch_req,
   input  wire [ADDR_W-1:0]            fetch_addr,
   output logic                        fetch_gnt,
   output logic                        fetch_rvalid,
   input  wire                         mover_req,
   input  wire                         mover_we,
   input  wire [ADDR_W-1:0]            mover_addr,
   input  wire [adma_pkg::data_w-1:0]  mover_wdata,
   output logic                        mover_gnt,
   output logic                        mover_rvalid,
   output logic [ADDR_W-1:0]           ram_addr,
   output logic                        ram_we,
   output logic [adma_pkg::data_w-1:0] ram_wdata
);

   logic [2:0] rd_owner;   // {mover, fetch, host}

   // host is never refused
   assign fetch_gnt = fetch_req && !host_req;
   assign mover_gnt = mover_req && !host_req && !fetch_req;

   always_comb begin
      ram_addr  = mover_addr;
      ram_we    = mover_gnt && mover_we;
      ram_wdata = mover_wdata;
      if (host_req) begin
         ram_addr  = host_addr;
         ram_we    = host_we;
         ram_wdata = host_wdata;
      end else if (fetch_req) begin
         ram_addr = fetch_addr;   // fetcher only reads
         ram_we   = 1'b0;
      end
   end

   // who gets the ram data on the next cycle
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         rd_owner <= '0;
      end else begin
         rd_owner <= {mover_gnt && !mover_we, fetch_gnt, host_req && !host_we};
      end
   end

   assign host_rvalid  = rd_owner[0];
   assign fetch_rvalid = rd_owner[1];
   assign mover_rvalid = rd_owner[2];

   ////////////////////
   // protocol checks
   ////////////////////
   a_gnt_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
      $onehot0({host_req, fetch_gnt, mover_gnt}));

   // a waiting requester keeps asking
   a_mover_hold: assert property (@(posedge CLK) disable iff (!rst_n)
      mover_req && !mover_gnt |=> mover_req);
   a_fetch_hold: assert property (@(posedge CLK) disable iff (!rst_n)
      fetch_req && !fetch_gnt |=> fetch_req);

endmodule

`default_nettype wire

/* logic/system_ram.sv */
/*
 * system ram
 * single port word memory, read data registered one cycle after the address
 */
`timescale 1ns/1ps
`default_nettype none

module system_ram #(
   parameter int ADDR_W = 8
) (
   input  wire                        CLK,
   input  wire [ADDR_W-1:0]           addr,
   input  wire                        we,
   input  wire [adma_pkg::data_w-1:0] wdata,
   output logic [adma_pkg::data_w-1:0] rdata
);

   logic [adma_pkg::data_w-1:0] mem [2**ADDR_W];

   always_ff @(posedge CLK) begin
      if (we) begin
         mem[addr] <= wdata;
      end else begin
         rdata <= mem[addr];   // held across write cycles
      end
   end

endmodule

`default_nettype wire

/* logic/adma_pkg.sv */
/*
 * adma shared definitions
 * word widths, descriptor action codes and the attribute word layout
 */
`default_nettype none

package adma_pkg;

   localparam int data_w = 32;   // system bus word
   localparam int len_w  = 16;   // descriptor length field

   ////////////////////
   // descriptor actions
   ////////////////////
   localparam logic [1:0] act_nop  = 2'b00;
   localparam logic [1:0] act_tran = 2'b10;
   localparam logic [1:0] act_link = 2'b11;
   // 2'b01 is reserved and handled like nop

   // descriptor word 0, seen raw on the bus or split into fields
   typedef union packed {
      logic [data_w-1:0] raw;
      struct packed {
         logic             valid;     // descriptor may be used
         logic             end_flag;  // last descriptor of the chain
         logic [1:0]       rsvd;
         logic [1:0]       act;
         logic [9:0]       spare;
         logic [len_w-1:0] length;    // words to move for tran
      } attr;
   } adma_attr_u;

endpackage

`default_nettype wire
